/* ramPkg.sv */
/* Defaults for a byte-wide asynchronous SRAM behind 32-bit host words.
   Other widths are set through the module parameters of ramSubsystem. */

package ramPkg;

	// ------------------------------
	// Default geometry
	// ------------------------------

	// Byte address, 512 KiB part
	localparam int cRamAdrsWidth = 19;

	// One byte per SRAM access
	localparam int cRamDqWidth = 8;

	// Host word is four bytes, low byte at the lowest address
	localparam int cBytesPerWord = 4;

	// Word address drops the two byte-select bits
	localparam int cWordAdrsWidth = cRamAdrsWidth - 2;

	// ------------------------------
	// Access command
	// ------------------------------

	// Read high, write low, as on the pin driver
	localparam logic cCmdRead = 1'b1;
	localparam logic cCmdWrite = 1'b0;

endpackage

/* ramIf.sv */
/* Pins change one cycle after an access is presented and hold for one cycle.
   The clock must be slow enough that one cycle meets every SRAM timing. */

`timescale 1ns/1ps

module ramIf #(
	parameter int pRamAdrsWidth = ramPkg::cRamAdrsWidth,
	parameter int pRamDqWidth = ramPkg::cRamDqWidth
)(
	input  logic iClk,
	input  logic reset,

	// Byte access from the sequencer
	input  logic [pRamAdrsWidth-1:0] adrs,
	input  logic [pRamDqWidth-1:0] wd,
	input  logic ce,
	input  logic cmd,
	output logic [pRamDqWidth-1:0] rd,
	output logic rdValid,

	// SRAM pins, controls active low
	output logic [pRamAdrsWidth-1:0] memAdrs,
	inout  wire  [pRamDqWidth-1:0] memDq,
	output logic memOe,
	output logic memWe,
	output logic memCe
);

	// ------------------------------
	// Pin truth table
	// ------------------------------
	// memCe high          deselected, bus floats
	// memCe low, We low   write, Oe ignored
	// memCe low, We high  read when Oe low, else bus floats
	// Write enable wins over output enable

	// Registered write byte for the bus
	logic [pRamDqWidth-1:0] wdQ;

	// Decoded state of the access now on the pins
	logic wrOnPins;
	logic rdOnPins;

	assign wrOnPins = ~memCe & ~memWe;
	assign rdOnPins = ~memCe & memWe & ~memOe;

	// ------------------------------
	// Control pins
	// ------------------------------

	always_ff @(posedge iClk)
	begin
		if (reset)
		begin
			// Deselected, nothing driven
			memCe <= 1'b1;
			memWe <= 1'b1;
			memOe <= 1'b1;
			rdValid <= 1'b0;
		end
		else
		begin
			memCe <= ce;
			// Strobes only for a selected access
			memWe <= ce | (cmd != ramPkg::cCmdWrite);
			memOe <= ce | (cmd != ramPkg::cCmdRead);
			// Flags the byte sampled at the end of a read cycle
			rdValid <= rdOnPins;
		end
	end

	// ------------------------------
	// Address, write data, capture
	// ------------------------------

	always_ff @(posedge iClk)
	begin
		memAdrs <= adrs;
		wdQ <= wd;
		// Sample the SRAM output at the end of its pin cycle
		if (rdOnPins)
		begin
			rd <= memDq;
		end
	end

	// Bus driven from the same register as memWe
	// so data and strobe switch together
	assign memDq = wrOnPins ? wdQ : {pRamDqWidth{1'bz}};

endmodule

/* ramWordSeq.sv */
/* Requests made while busy are dropped, there is no queue.
   Read words take pBytesPerWord+2 cycles, low byte from the lowest address. */

`timescale 1ns/1ps

module ramWordSeq #(
	parameter int pRamAdrsWidth = ramPkg::cRamAdrsWidth,
	parameter int pRamDqWidth = ramPkg::cRamDqWidth,
	parameter int pBytesPerWord = ramPkg::cBytesPerWord
)(
	input  logic iClk,
	input  logic reset,

	// Host side
	input  logic start,
	input  logic write,
	input  logic [pRamAdrsWidth-$clog2(pBytesPerWord)-1:0] wordAdrs,
	input  logic [pRamDqWidth*pBytesPerWord-1:0] wordWd,
	output logic [pRamDqWidth*pBytesPerWord-1:0] wordRd,
	output logic busy,
	output logic done,

	// Byte accesses toward the pin driver
	output logic [pRamAdrsWidth-1:0] adrs,
	output logic [pRamDqWidth-1:0] wd,
	output logic ce,
	output logic cmd,
	input  logic [pRamDqWidth-1:0] rd,
	input  logic rdValid
);

	// Counter wide enough to hold pBytesPerWord
	localparam int lCntWidth = $clog2(pBytesPerWord + 1);
	localparam logic [lCntWidth-1:0] lLastIssue = lCntWidth'(pBytesPerWord);
	localparam logic [lCntWidth-1:0] lLastRcv = lCntWidth'(pBytesPerWord - 1);

	// Bytes issued so far in this request
	logic [lCntWidth-1:0] issueCnt;
	// Read bytes returned so far
	logic [lCntWidth-1:0] rcvCnt;

	// Remaining write bytes, low byte next
	logic [pRamDqWidth*pBytesPerWord-1:0] wrShift;
	// Read word being assembled
	logic [pRamDqWidth*pBytesPerWord-1:0] rdAsm;
	logic [pRamDqWidth*pBytesPerWord-1:0] rdNext;

	logic accept;
	logic issueMore;

	// Only an idle sequencer takes a start
	assign accept = start & ~busy;

	// Another byte follows the one on the interface
	assign issueMore = ~ce & (issueCnt != lLastIssue);

	// Returning byte dropped into its slot
	always_comb
	begin
		rdNext = rdAsm;
		rdNext[rcvCnt*pRamDqWidth +: pRamDqWidth] = rd;
	end

	// ------------------------------
	// Control
	// ------------------------------

	always_ff @(posedge iClk)
	begin
		if (reset)
		begin
			ce <= 1'b1;
			busy <= 1'b0;
			done <= 1'b0;
			issueCnt <= '0;
			rcvCnt <= '0;
		end
		else
		begin
			done <= 1'b0;

			// First byte goes out on the accepting edge
			if (accept)
			begin
				ce <= 1'b0;
				busy <= 1'b1;
				issueCnt <= lCntWidth'(1);
			end
			else if (issueMore)
			begin
				issueCnt <= issueCnt + 1'b1;
			end
			else if (!ce)
			begin
				// Last byte was issued last cycle
				ce <= 1'b1;
				// Writes finish here
				if (cmd == ramPkg::cCmdWrite)
				begin
					done <= 1'b1;
					busy <= 1'b0;
				end
			end

			// Reads finish on the last returned byte
			// overlapping the issue of later bytes
			if (rdValid)
			begin
				if (rcvCnt == lLastRcv)
				begin
					rcvCnt <= '0;
					done <= 1'b1;
					busy <= 1'b0;
				end
				else
				begin
					rcvCnt <= rcvCnt + 1'b1;
				end
			end
		end
	end

	// ------------------------------
	// Address and data path
	// ------------------------------

	always_ff @(posedge iClk)
	begin
		if (accept)
		begin
			cmd <= write ? ramPkg::cCmdWrite : ramPkg::cCmdRead;
			// Word base in byte addresses
			adrs <= pRamAdrsWidth'(wordAdrs * pBytesPerWord);
			wd <= wordWd[pRamDqWidth-1:0];
			wrShift <= wordWd >> pRamDqWidth;
		end
		else if (issueMore)
		begin
			adrs <= adrs + 1'b1;
			wd <= wrShift[pRamDqWidth-1:0];
			wrShift <= wrShift >> pRamDqWidth;
		end

		if (rdValid)
		begin
			rdAsm <= rdNext;
			// Host word only changes when a read completes
			if (rcvCnt == lLastRcv)
			begin
				wordRd <= rdNext;
			end
		end
	end

endmodule

/* ramSubsystem.sv */
/* Host word port over a byte-wide asynchronous SRAM.
   Widths default to ramPkg and are passed down to both blocks. */

`timescale 1ns/1ps

module ramSubsystem #(
	parameter int pRamAdrsWidth = ramPkg::cRamAdrsWidth,
	parameter int pRamDqWidth = ramPkg::cRamDqWidth,
	parameter int pBytesPerWord = ramPkg::cBytesPerWord
)(
	input  logic iClk,
	input  logic reset,

	// Host word requests
	input  logic start,
	input  logic write,
	input  logic [pRamAdrsWidth-$clog2(pBytesPerWord)-1:0] wordAdrs,
	input  logic [pRamDqWidth*pBytesPerWord-1:0] wordWd,
	output logic [pRamDqWidth*pBytesPerWord-1:0] wordRd,
	output logic busy,
	output logic done,

	// SRAM pins
	output logic [pRamAdrsWidth-1:0] memAdrs,
	inout  wire  [pRamDqWidth-1:0] memDq,
	output logic memOe,
	output logic memWe,
	output logic memCe
);

	// ------------------------------
	// Byte access link
	// ------------------------------
	logic [pRamAdrsWidth-1:0] adrs;
	logic [pRamDqWidth-1:0] wd;
	logic [pRamDqWidth-1:0] rd;
	logic ce;
	logic cmd;
	logic rdValid;

	// Word to byte splitting and read assembly
	ramWordSeq #(
		.pRamAdrsWidth(pRamAdrsWidth),
		.pRamDqWidth(pRamDqWidth),
		.pBytesPerWord(pBytesPerWord)
	) u_ramWordSeq (
		.iClk(iClk),
		.reset(reset),
		.start(start),
		.write(write),
		.wordAdrs(wordAdrs),
		.wordWd(wordWd),
		.wordRd(wordRd),
		.busy(busy),
		.done(done),
		.adrs(adrs),
		.wd(wd),
		.ce(ce),
		.cmd(cmd),
		.rd(rd),
		.rdValid(rdValid)
	);

	// Registered pins and bus turnaround
	ramIf #(
		.pRamAdrsWidth(pRamAdrsWidth),
		.pRamDqWidth(pRamDqWidth)
	) u_ramIf (
		.iClk(iClk),
		.reset(reset),
		.adrs(adrs),
		.wd(wd),
		.ce(ce),
		.cmd(cmd),
		.rd(rd),
		.rdValid(rdValid),
		.memAdrs(memAdrs),
		.memDq(memDq),
		.memOe(memOe),
		.memWe(memWe),
		.memCe(memCe)
	);

endmodule

/* ramIf_properties.sv */
/* Pin timing checks for ramIf, attached by bind to every instance.
   Checks are off while reset is high except the reset check itself. */

`timescale 1ns/1ps

module ramIf_properties (
	input logic iClk,
	input logic reset,
	input logic memCe,
	input logic memWe,
	input logic memOe,
	input logic rdValid
);

	// Selected read now on the pins
	logic rdOnPins;
	assign rdOnPins = ~memCe & memWe & ~memOe;

	// ------------------------------
	// Strobes and read latency
	// ------------------------------

	// Never both strobes low on a selected part
	strobeClash: assert property (@(posedge iClk) disable iff (reset)
		!memCe |-> (memWe || memOe))
		else $error("Write enable and output enable both low while selected");

	// Read byte flagged exactly one cycle later
	rdFollows: assert property (@(posedge iClk) disable iff (reset)
		rdOnPins |=> rdValid)
		else $error("rdValid missing one cycle after a read on the pins");

	rdOnlyAfterRead: assert property (@(posedge iClk) disable iff (reset)
		rdValid |-> $past(rdOnPins))
		else $error("rdValid raised without a read on the pins");

	// Deselected right after reset
	idleAfterReset: assert property (@(posedge iClk)
		reset |=> memCe)
		else $error("memCe low in the cycle after reset");

endmodule

bind ramIf ramIf_properties u_ramIfProperties (
	.iClk(iClk),
	.reset(reset),
	.memCe(memCe),
	.memWe(memWe),
	.memOe(memOe),
	.rdValid(rdValid)
);

/* tbSramModel.sv */
/* Asynchronous SRAM with zero access time, writes follow the bus while selected.
   Unwritten bytes hold a fill pattern folded from the whole address. */

`timescale 1ns/1ps

module tbSramModel #(
	parameter int pAdrsWidth = ramPkg::cRamAdrsWidth,
	parameter int pDqWidth = ramPkg::cRamDqWidth
)(
	input  logic [pAdrsWidth-1:0] memAdrs,
	inout  wire  [pDqWidth-1:0] memDq,
	input  logic memOe,
	input  logic memWe,
	input  logic memCe
);

	logic [pDqWidth-1:0] mem [0:(1<<pAdrsWidth)-1];
	logic rdDrive;

	// Every address bit folds into the byte
	function automatic logic [pDqWidth-1:0] fillByte(input int adrs);
		logic [pDqWidth-1:0] v;
		v = pDqWidth'(32'h5a5a5a5a);
		for (int b = 0; b < 32; b += pDqWidth)
		begin
			v ^= pDqWidth'(adrs >> b);
		end
		return v;
	endfunction

	initial
	begin
		for (int i = 0; i < (1 << pAdrsWidth); i++)
		begin
			mem[i] = fillByte(i);
		end
	end

	// Write enable wins, output enable ignored
	always @(memAdrs or memDq or memWe or memCe)
	begin
		if (!memCe && !memWe)
		begin
			mem[memAdrs] = memDq;
		end
	end

	// Drive only a selected read
	assign rdDrive = ~memCe & memWe & ~memOe;
	assign memDq = rdDrive ? mem[memAdrs] : {pDqWidth{1'bz}};

endmodule

/* tbRamSubsystem.sv */
/* Random word traffic over a small window, checked against a word reference.
   Inputs change 0.5 ns after the rising edge and outputs are read there too. */

`timescale 1ns/1ps

module tbRamSubsystem;

	localparam int cAdrsWidth = ramPkg::cRamAdrsWidth;
	localparam int cDqWidth = ramPkg::cRamDqWidth;
	localparam int cBytes = ramPkg::cBytesPerWord;
	localparam int cWordAdrsWidth = ramPkg::cWordAdrsWidth;
	localparam int cWordWidth = cDqWidth * cBytes;
	localparam int cResetCycles = 16;
	localparam int cWindow = 16;
	localparam int cNumRandom = 200;
	// Requests of all tests, the ignored start included
	localparam int cNumRequests = 2 + 1 + cWindow + cNumRandom + 4;
	localparam int cTimeout = cNumRequests * (cBytes + 4) + cResetCycles + 200;

	logic iClk = 1'b0;
	logic reset;
	logic start;
	logic write;
	logic [cWordAdrsWidth-1:0] wordAdrs;
	logic [cWordWidth-1:0] wordWd;
	wire  [cWordWidth-1:0] wordRd;
	wire  busy;
	wire  done;
	wire  [cAdrsWidth-1:0] memAdrs;
	wire  [cDqWidth-1:0] memDq;
	wire  memOe;
	wire  memWe;
	wire  memCe;

	integer seed = 32'h3d021a9b;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int cycleCount = 0;
	// Word reference keyed by word address
	logic [cWordWidth-1:0] refMem [int];

	ramSubsystem #(
		.pRamAdrsWidth(cAdrsWidth),
		.pRamDqWidth(cDqWidth),
		.pBytesPerWord(cBytes)
	) u_ramSubsystem (
		.iClk(iClk), .reset(reset), .start(start), .write(write),
		.wordAdrs(wordAdrs), .wordWd(wordWd), .wordRd(wordRd),
		.busy(busy), .done(done), .memAdrs(memAdrs), .memDq(memDq),
		.memOe(memOe), .memWe(memWe), .memCe(memCe)
	);

	tbSramModel #(
		.pAdrsWidth(cAdrsWidth),
		.pDqWidth(cDqWidth)
	) u_sramModel (
		.memAdrs(memAdrs), .memDq(memDq), .memOe(memOe), .memWe(memWe), .memCe(memCe)
	);

	// 4 ns clock
	always #2 iClk = ~iClk;

	// Run limit
	always @(posedge iClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cTimeout)
		begin
			$display("Timeout after %0d cycles, no done from the DUT", cycleCount);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ------------------------------
	// Helpers
	// ------------------------------

	task automatic checkValue(input string name, input logic [cWordWidth-1:0] got,
			input logic [cWordWidth-1:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errorCount++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// One request, latency counted from the accepting edge
	task automatic runRequest(input logic isWrite, input logic [cWordAdrsWidth-1:0] adrs,
			input logic [cWordWidth-1:0] data, output logic [cWordWidth-1:0] rdata,
			output int latency);
		int edges;
		start = 1'b1;
		write = isWrite;
		wordAdrs = adrs;
		wordWd = data;
		@(posedge iClk);
		#0.5;
		start = 1'b0;
		edges = 1;
		while (done !== 1'b1)
		begin
			@(posedge iClk);
			#0.5;
			edges++;
		end
		latency = edges - 1;
		rdata = wordRd;
	endtask

	task automatic writeWord(input logic [cWordAdrsWidth-1:0] adrs,
			input logic [cWordWidth-1:0] data);
		logic [cWordWidth-1:0] unused;
		int lat;
		runRequest(1'b1, adrs, data, unused, lat);
		// Done one cycle after the last byte issue
		checkValue("write done latency", lat, cBytes);
		refMem[int'(adrs)] = data;
	endtask

	task automatic readCompare(input logic [cWordAdrsWidth-1:0] adrs);
		logic [cWordWidth-1:0] got;
		int lat;
		runRequest(1'b0, adrs, '0, got, lat);
		checkValue("read done latency", lat, cBytes + 2);
		checkValue("wordRd", got, refMem[int'(adrs)]);
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
		begin
			$display("Test %0d %s: ok", testCount, name);
		end
		else
		begin
			$display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
		end
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------

	initial
	begin
		logic [cWordAdrsWidth-1:0] a1;
		logic [cWordAdrsWidth-1:0] a2;
		logic [cWordAdrsWidth-1:0] base;
		logic [cWordWidth-1:0] w1;
		int errorsBefore;
		int doneCount;
		reset = 1'b1;
		start = 1'b0;
		write = 1'b0;
		wordAdrs = '0;
		wordWd = '0;
		repeat (cResetCycles) @(posedge iClk);
		#0.5;
		reset = 1'b0;

		// Idle pins and host flags
		errorsBefore = errorCount;
		checkValue("memCe", memCe, 1);
		checkValue("memWe", memWe, 1);
		checkValue("memOe", memOe, 1);
		checkValue("busy", busy, 0);
		checkValue("done", done, 0);
		finishTest("reset state", errorsBefore);

		errorsBefore = errorCount;
		a1 = cWordAdrsWidth'($random(seed));
		w1 = cWordWidth'($random(seed));
		writeWord(a1, w1);
		readCompare(a1);
		finishTest("write then read", errorsBefore);

		// Low byte at the lowest byte address
		errorsBefore = errorCount;
		a1 = cWordAdrsWidth'($random(seed));
		w1 = cWordWidth'($random(seed));
		writeWord(a1, w1);
		for (int i = 0; i < cBytes; i++)
		begin
			checkValue($sformatf("SRAM byte %0d", i), u_sramModel.mem[int'(a1) * cBytes + i],
				w1[i*cDqWidth +: cDqWidth]);
		end
		finishTest("byte order", errorsBefore);

		// Window filled first so every read has a reference
		errorsBefore = errorCount;
		base = cWordAdrsWidth'($random(seed)) & ~cWordAdrsWidth'(cWindow - 1);
		for (int i = 0; i < cWindow; i++)
		begin
			writeWord(base + cWordAdrsWidth'(i), cWordWidth'($random(seed)));
		end
		for (int n = 0; n < cNumRandom; n++)
		begin
			a1 = base + cWordAdrsWidth'($random(seed) & (cWindow - 1));
			if ($random(seed) & 1)
				writeWord(a1, cWordWidth'($random(seed)));
			else
				readCompare(a1);
		end
		finishTest("random traffic", errorsBefore);

		// Second start lands while the first write is busy
		errorsBefore = errorCount;
		a1 = base;
		a2 = base + cWordAdrsWidth'(5);
		w1 = cWordWidth'($random(seed));
		doneCount = 0;
		start = 1'b1;
		write = 1'b1;
		wordAdrs = a1;
		wordWd = w1;
		@(posedge iClk);
		#0.5;
		start = 1'b0;
		@(posedge iClk);
		#0.5;
		checkValue("busy", busy, 1);
		start = 1'b1;
		wordAdrs = a2;
		wordWd = ~w1;
		@(posedge iClk);
		#0.5;
		start = 1'b0;
		repeat (12)
		begin
			doneCount += done;
			@(posedge iClk);
			#0.5;
		end
		checkValue("done count", doneCount, 1);
		refMem[int'(a1)] = w1;
		readCompare(a2);
		readCompare(a1);
		finishTest("start while busy", errorsBefore);

		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* Makefile */
# Verilator build and run for the SRAM subsystem testbench

VERILATOR ?= verilator
TOP       ?= tbRamSubsystem
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG := >>> PASS
FAIL_MSG := >>> FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the log, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q -F '$(FAIL_MSG)' $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q -F '$(PASS_MSG)' $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb.f */
ramPkg.sv
ramIf.sv
ramWordSeq.sv
ramSubsystem.sv
ramIf_properties.sv
tbSramModel.sv
tbRamSubsystem.sv
